// File: src/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

  localparam int xlen = 64;  // register and address width

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opOp     = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeT;

  typedef enum logic [2:0] {
    fmtI = 3'd0,
    fmtU = 3'd1,
    fmtS = 3'd2,
    fmtB = 3'd3,
    fmtJ = 3'd4,
    fmtR = 3'd5  // no immediate
  } immFmtT;

  localparam logic [2:0] f3AddSub = 3'b000;  // integer group
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  localparam logic [2:0] f3Beq    = 3'b000;  // branch group
  localparam logic [2:0] f3Bne    = 3'b001;
  localparam logic [2:0] f3Blt    = 3'b100;
  localparam logic [2:0] f3Bge    = 3'b101;
  localparam logic [2:0] f3Bltu   = 3'b110;
  localparam logic [2:0] f3Bgeu   = 3'b111;

endpackage

`default_nettype wire

// File: src/coreCtrlPkg.sv
`default_nettype none

package coreCtrlPkg;

  // bit 3 set for the alternate op picked by instr[30]
  typedef enum logic [3:0] {
    aluAdd   = 4'b0000,
    aluSll   = 4'b0001,
    aluSlt   = 4'b0010,
    aluSltu  = 4'b0011,
    aluXor   = 4'b0100,
    aluSrl   = 4'b0101,
    aluOr    = 4'b0110,
    aluAnd   = 4'b0111,
    aluSub   = 4'b1000,
    aluSra   = 4'b1101,
    aluPassB = 4'b1111  // lui
  } aluOpT;

  typedef enum logic [1:0] {
    srcRs2  = 2'd0,
    srcImm  = 2'd1,
    srcFour = 2'd2  // link address via alu
  } srcBT;

  typedef enum logic [2:0] {
    brNone = 3'b000,
    brJal  = 3'b001,
    brJalr = 3'b010,
    brBeq  = 3'b100,
    brBne  = 3'b101,
    brBlt  = 3'b110,  // also bltu, alu picks compare
    brBge  = 3'b111   // also bgeu
  } branchT;

  // same code as load/store funct3
  typedef enum logic [2:0] {
    memB    = 3'b000,
    memH    = 3'b001,
    memW    = 3'b010,
    memD    = 3'b011,
    memBu   = 3'b100,
    memHu   = 3'b101,
    memWu   = 3'b110,
    memNone = 3'b111
  } memOpT;

endpackage

`default_nettype wire

// File: src/ctrlBus.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlBus;
  logic                aluSrcA;   // 1 rs1 else pc
  coreCtrlPkg::srcBT   aluSrcB;
  rvIsaPkg::immFmtT    immFmt;
  coreCtrlPkg::aluOpT  aluOp;
  coreCtrlPkg::branchT branch;
  coreCtrlPkg::memOpT  memOp;
  logic                memRead;
  logic                memWrite;
  logic                memToReg;  // load data to rd
  logic                regWen;

  modport dec (output aluSrcA, aluSrcB, immFmt, aluOp, branch, memOp,
               output memRead, memWrite, memToReg, regWen);
  modport dp (input aluSrcA, aluSrcB, immFmt, aluOp, branch, memOp,
              input memRead, memWrite, memToReg, regWen);
endinterface

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
  input  logic [31:0] instr,
  ctrlBus.dec         ctrl,
  output logic        halt,     // ebreak
  output logic        illegal   // unknown encoding, runs as nop
);
  rvIsaPkg::opcodeT   opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  coreCtrlPkg::aluOpT arithOp;   // shared by op and op-imm
  logic               arithBad;  // reserved funct7 or shamt bits

  assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    case (funct3)
      rvIsaPkg::f3AddSub: arithOp = (instr[30] && opcode == rvIsaPkg::opOp) ?
                                    coreCtrlPkg::aluSub : coreCtrlPkg::aluAdd;  // no subi
      rvIsaPkg::f3Sll:    arithOp = coreCtrlPkg::aluSll;
      rvIsaPkg::f3Slt:    arithOp = coreCtrlPkg::aluSlt;
      rvIsaPkg::f3Sltu:   arithOp = coreCtrlPkg::aluSltu;
      rvIsaPkg::f3Xor:    arithOp = coreCtrlPkg::aluXor;
      rvIsaPkg::f3SrlSra: arithOp = instr[30] ? coreCtrlPkg::aluSra : coreCtrlPkg::aluSrl;
      rvIsaPkg::f3Or:     arithOp = coreCtrlPkg::aluOr;
      default:            arithOp = coreCtrlPkg::aluAnd;
    endcase
  end

  always_comb begin
    if (opcode == rvIsaPkg::opOp)  // only 0000000, or 0100000 for sub/sra
      arithBad = !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 &&
                   (funct3 == rvIsaPkg::f3AddSub || funct3 == rvIsaPkg::f3SrlSra)));
    else if (funct3 == rvIsaPkg::f3Sll)
      arithBad = instr[31:26] != 6'd0;  // 6-bit shamt
    else if (funct3 == rvIsaPkg::f3SrlSra)
      arithBad = (instr[31:26] & 6'b101111) != 6'd0;  // bit 30 free
    else
      arithBad = 1'b0;
  end

  always_comb begin
    ctrl.aluSrcA  = 1'b1;
    ctrl.aluSrcB  = coreCtrlPkg::srcImm;
    ctrl.immFmt   = rvIsaPkg::fmtI;
    ctrl.aluOp    = coreCtrlPkg::aluAdd;
    ctrl.branch   = coreCtrlPkg::brNone;
    ctrl.memOp    = coreCtrlPkg::memNone;
    ctrl.memRead  = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWen   = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    case (opcode)
      rvIsaPkg::opLui: begin
        ctrl.immFmt = rvIsaPkg::fmtU;
        ctrl.aluOp  = coreCtrlPkg::aluPassB;
        ctrl.regWen = 1'b1;
      end
      rvIsaPkg::opAuipc: begin
        ctrl.aluSrcA = 1'b0;  // pc + imm
        ctrl.immFmt  = rvIsaPkg::fmtU;
        ctrl.regWen  = 1'b1;
      end
      rvIsaPkg::opJal, rvIsaPkg::opJalr: begin
        ctrl.aluSrcA = 1'b0;  // pc + 4 to rd
        ctrl.aluSrcB = coreCtrlPkg::srcFour;
        ctrl.regWen  = 1'b1;
        if (opcode == rvIsaPkg::opJal) begin
          ctrl.immFmt = rvIsaPkg::fmtJ;
          ctrl.branch = coreCtrlPkg::brJal;
        end else begin
          ctrl.branch = coreCtrlPkg::brJalr;
          illegal     = funct3 != 3'b000;
        end
      end
      rvIsaPkg::opImm, rvIsaPkg::opOp: begin
        ctrl.aluOp  = arithOp;
        ctrl.regWen = 1'b1;
        illegal     = arithBad;
        if (opcode == rvIsaPkg::opOp) begin
          ctrl.aluSrcB = coreCtrlPkg::srcRs2;
          ctrl.immFmt  = rvIsaPkg::fmtR;
        end
      end
      rvIsaPkg::opBranch: begin
        ctrl.aluSrcB = coreCtrlPkg::srcRs2;
        ctrl.immFmt  = rvIsaPkg::fmtB;
        ctrl.aluOp   = funct3[1] ? coreCtrlPkg::aluSltu : coreCtrlPkg::aluSlt;  // unsigned pair
        case (funct3)
          rvIsaPkg::f3Beq:                  ctrl.branch = coreCtrlPkg::brBeq;
          rvIsaPkg::f3Bne:                  ctrl.branch = coreCtrlPkg::brBne;
          rvIsaPkg::f3Blt, rvIsaPkg::f3Bltu: ctrl.branch = coreCtrlPkg::brBlt;
          rvIsaPkg::f3Bge, rvIsaPkg::f3Bgeu: ctrl.branch = coreCtrlPkg::brBge;
          default:                          illegal = 1'b1;
        endcase
      end
      rvIsaPkg::opLoad: begin
        ctrl.memOp    = coreCtrlPkg::memOpT'(funct3);
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWen   = 1'b1;
        illegal       = funct3 == 3'b111;  // no ldu
      end
      rvIsaPkg::opStore: begin
        ctrl.immFmt   = rvIsaPkg::fmtS;
        ctrl.memOp    = coreCtrlPkg::memOpT'(funct3);
        ctrl.memWrite = 1'b1;
        illegal       = funct3[2];
      end
      rvIsaPkg::opSystem: begin
        if (instr[31:20] == 12'd1 && instr[19:7] == 13'd0)
          halt = 1'b1;  // ebreak
        else
          illegal = 1'b1;  // ecall, csr ops
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin  // squash side effects, pc still moves by 4
      ctrl.branch   = coreCtrlPkg::brNone;
      ctrl.memOp    = coreCtrlPkg::memNone;
      ctrl.memRead  = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.regWen   = 1'b0;
    end
  end

  always_comb begin
    noRdWr: assert final (!(ctrl.memRead && ctrl.memWrite))
      else $error("decoder drives memRead and memWrite together");
  end
endmodule

`default_nettype wire

// File: src/immGen.sv
`timescale 1ns/1ns
`default_nettype none

module immGen (
  input  logic [31:0]                instr,
  ctrlBus.dp                         ctrl,
  output logic [rvIsaPkg::xlen-1:0] imm
);
  logic sign;  // every format takes sign from bit 31

  assign sign = instr[31];

  always_comb begin
    case (ctrl.immFmt)
      rvIsaPkg::fmtI: imm = {{(rvIsaPkg::xlen-12){sign}}, instr[31:20]};
      rvIsaPkg::fmtS: imm = {{(rvIsaPkg::xlen-12){sign}}, instr[31:25], instr[11:7]};
      rvIsaPkg::fmtB: imm = {{(rvIsaPkg::xlen-13){sign}}, sign, instr[7], instr[30:25],
                             instr[11:8], 1'b0};  // halfword offset
      rvIsaPkg::fmtU: imm = {{(rvIsaPkg::xlen-32){sign}}, instr[31:12], 12'd0};
      rvIsaPkg::fmtJ: imm = {{(rvIsaPkg::xlen-21){sign}}, sign, instr[19:12], instr[20],
                             instr[30:21], 1'b0};
      default:        imm = '0;  // r-type
    endcase
  end
endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic [rvIsaPkg::xlen-1:0] a,
  input  logic [rvIsaPkg::xlen-1:0] b,
  ctrlBus.dp                        ctrl,
  output logic [rvIsaPkg::xlen-1:0] result,
  output logic                      zero,   // a == b for beq/bne
  output logic                      less    // signed unless sltu
);
  logic [5:0] shamt;

  assign shamt = b[5:0];  // rv64 shifts ignore upper bits
  assign zero  = a == b;
  assign less  = (ctrl.aluOp == coreCtrlPkg::aluSltu) ? (a < b) : ($signed(a) < $signed(b));

  always_comb begin
    case (ctrl.aluOp)
      coreCtrlPkg::aluAdd:   result = a + b;
      coreCtrlPkg::aluSub:   result = a - b;
      coreCtrlPkg::aluSll:   result = a << shamt;
      coreCtrlPkg::aluSlt,
      coreCtrlPkg::aluSltu:  result = {{(rvIsaPkg::xlen-1){1'b0}}, less};  // compare picks sign
      coreCtrlPkg::aluXor:   result = a ^ b;
      coreCtrlPkg::aluSrl:   result = a >> shamt;
      coreCtrlPkg::aluSra:   result = $signed(a) >>> shamt;
      coreCtrlPkg::aluOr:    result = a | b;
      coreCtrlPkg::aluAnd:   result = a & b;
      default:               result = b;  // passB for lui
    endcase
  end

  always_comb begin
    opKnown: assert final (ctrl.aluOp inside {coreCtrlPkg::aluAdd, coreCtrlPkg::aluSub,
        coreCtrlPkg::aluSll, coreCtrlPkg::aluSlt, coreCtrlPkg::aluSltu, coreCtrlPkg::aluXor,
        coreCtrlPkg::aluSrl, coreCtrlPkg::aluSra, coreCtrlPkg::aluOr, coreCtrlPkg::aluAnd,
        coreCtrlPkg::aluPassB})
      else $error("alu op %b is not a defined operation", ctrl.aluOp);
  end
endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [4:0]                rs1Addr,
  input  logic [4:0]                rs2Addr,
  output logic [rvIsaPkg::xlen-1:0] rs1Data,
  output logic [rvIsaPkg::xlen-1:0] rs2Data,
  input  logic                      wen,     // already qualified by commit
  input  logic [4:0]                rdAddr,
  input  logic [rvIsaPkg::xlen-1:0] rdData
);
  logic [rvIsaPkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && rdAddr != 5'd0) begin  // x0 never written
      regs[rdAddr] <= rdData;
    end
  end

  assign rs1Data = regs[rs1Addr];  // async reads
  assign rs2Data = regs[rs2Addr];

  x0Zero: assert property (@(posedge clk) disable iff (reset)
    wen && rdAddr == 5'd0 |=> regs[0] == '0)
    else $error("x0 changed after a write to it");
endmodule

`default_nettype wire

// File: src/pcUnit.sv
`timescale 1ns/1ns
`default_nettype none

module pcUnit #(
  parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      commit,   // instrValid and not halted
  input  logic                      haltReq,  // ebreak decoded
  ctrlBus.dp                        ctrl,
  input  logic [rvIsaPkg::xlen-1:0] imm,
  input  logic [rvIsaPkg::xlen-1:0] rs1Data,
  input  logic                      zero,
  input  logic                      less,
  output logic [rvIsaPkg::xlen-1:0] pc,
  output logic [rvIsaPkg::xlen-1:0] linkPc,
  output logic                      halted
);
  logic                      taken;
  logic [rvIsaPkg::xlen-1:0] nextPc;

  always_comb begin
    case (ctrl.branch)
      coreCtrlPkg::brBeq: taken = zero;
      coreCtrlPkg::brBne: taken = !zero;
      coreCtrlPkg::brBlt: taken = less;
      coreCtrlPkg::brBge: taken = !less;
      default:            taken = 1'b0;
    endcase
  end

  assign linkPc = pc + 4;
  assign nextPc = (ctrl.branch == coreCtrlPkg::brJalr) ? ((rs1Data + imm) & ~64'd1) :
                  (ctrl.branch == coreCtrlPkg::brJal || taken) ? pc + imm : linkPc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= resetPc;
      halted <= 1'b0;
    end else if (commit) begin
      pc <= nextPc;
      if (haltReq)
        halted <= 1'b1;  // sticky until reset
    end
  end

  haltHold: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else $error("pc moved while halted");
endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
  ctrlBus.dp                        ctrl,
  input  logic [rvIsaPkg::xlen-1:0] addr,
  input  logic [rvIsaPkg::xlen-1:0] storeData,  // rs2
  input  logic [rvIsaPkg::xlen-1:0] aluResult,
  input  logic [rvIsaPkg::xlen-1:0] linkPc,
  input  logic [rvIsaPkg::xlen-1:0] memRdata,   // aligned doubleword
  output logic [rvIsaPkg::xlen-1:0] memWdata,
  output logic [7:0]                memMask,
  output logic [rvIsaPkg::xlen-1:0] wbData
);
  logic [2:0]                byteOff;
  logic [5:0]                bitOff;
  logic [7:0]                sizeMask;   // strobes before lane shift
  logic [2:0]                alignMask;  // offset bits that must be zero
  logic [rvIsaPkg::xlen-1:0] lane;
  logic [rvIsaPkg::xlen-1:0] loadData;
  logic                      isJump;

  assign byteOff   = addr[2:0];
  assign bitOff    = {byteOff, 3'b000};
  assign memWdata  = storeData << bitOff;
  assign alignMask = {&ctrl.memOp[1:0], ctrl.memOp[1], |ctrl.memOp[1:0]};

  always_comb begin
    case (ctrl.memOp[1:0])
      2'd0:    sizeMask = 8'h01;
      2'd1:    sizeMask = 8'h03;
      2'd2:    sizeMask = 8'h0f;
      default: sizeMask = 8'hff;
    endcase
  end

  assign memMask = ctrl.memWrite ? (sizeMask << byteOff) : 8'h00;
  assign lane    = memRdata >> bitOff;  // addressed bytes to bit 0

  always_comb begin
    case (ctrl.memOp)
      coreCtrlPkg::memB:  loadData = {{(rvIsaPkg::xlen-8){lane[7]}}, lane[7:0]};
      coreCtrlPkg::memH:  loadData = {{(rvIsaPkg::xlen-16){lane[15]}}, lane[15:0]};
      coreCtrlPkg::memW:  loadData = {{(rvIsaPkg::xlen-32){lane[31]}}, lane[31:0]};
      coreCtrlPkg::memBu: loadData = {{(rvIsaPkg::xlen-8){1'b0}}, lane[7:0]};
      coreCtrlPkg::memHu: loadData = {{(rvIsaPkg::xlen-16){1'b0}}, lane[15:0]};
      coreCtrlPkg::memWu: loadData = {{(rvIsaPkg::xlen-32){1'b0}}, lane[31:0]};
      default:            loadData = lane;  // ld
    endcase
  end

  assign isJump = ctrl.branch == coreCtrlPkg::brJal || ctrl.branch == coreCtrlPkg::brJalr;
  assign wbData = ctrl.memToReg ? loadData : isJump ? linkPc : aluResult;

  always_comb begin
    storeAligned: assert final (!ctrl.memWrite || (byteOff & alignMask) == 3'd0)
      else $error("misaligned store at %h", addr);
  end
endmodule

`default_nettype wire

// File: src/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvCore #(
  parameter logic [rvIsaPkg::xlen-1:0] resetPc = 64'h0000_0000_8000_0000
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [31:0]               instr,
  input  logic                      instrValid,  // low stalls the core
  output logic [rvIsaPkg::xlen-1:0] pc,
  output logic [rvIsaPkg::xlen-1:0] memAddr,
  output logic [rvIsaPkg::xlen-1:0] memWdata,
  output logic [7:0]                memMask,
  output logic                      memWrite,
  output logic                      memRead,
  input  logic [rvIsaPkg::xlen-1:0] memRdata,
  output logic                      halted,
  output logic                      illegal
);
  logic                      commit;
  logic                      decHalt;
  logic                      decIllegal;
  logic [rvIsaPkg::xlen-1:0] imm;
  logic [rvIsaPkg::xlen-1:0] rs1Data;
  logic [rvIsaPkg::xlen-1:0] rs2Data;
  logic [rvIsaPkg::xlen-1:0] aluA;
  logic [rvIsaPkg::xlen-1:0] aluB;
  logic [rvIsaPkg::xlen-1:0] aluResult;
  logic                      zero;
  logic                      less;
  logic [rvIsaPkg::xlen-1:0] linkPc;
  logic [rvIsaPkg::xlen-1:0] wbData;

  ctrlBus ctrlIf ();

  assign commit   = instrValid & ~halted;  // one instruction per edge
  assign illegal  = instrValid & decIllegal;
  assign memWrite = commit & ctrlIf.memWrite;
  assign memRead  = commit & ctrlIf.memRead;
  assign memAddr  = aluResult;  // rs1 + imm
  assign aluA     = ctrlIf.aluSrcA ? rs1Data : pc;
  assign aluB     = (ctrlIf.aluSrcB == coreCtrlPkg::srcImm)  ? imm :
                    (ctrlIf.aluSrcB == coreCtrlPkg::srcFour) ? 64'd4 : rs2Data;

  instrDecoder i_instrDecoder (.instr(instr), .ctrl(ctrlIf.dec), .halt(decHalt),
                               .illegal(decIllegal));

  immGen i_immGen (.instr(instr), .ctrl(ctrlIf.dp), .imm(imm));

  alu i_alu (.a(aluA), .b(aluB), .ctrl(ctrlIf.dp), .result(aluResult), .zero(zero),
             .less(less));

  regFile i_regFile (.clk(clk), .reset(reset), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
                     .rs1Data(rs1Data), .rs2Data(rs2Data), .wen(commit & ctrlIf.regWen),
                     .rdAddr(instr[11:7]), .rdData(wbData));

  pcUnit #(.resetPc(resetPc)) i_pcUnit (
    .clk(clk), .reset(reset), .commit(commit), .haltReq(decHalt), .ctrl(ctrlIf.dp),
    .imm(imm), .rs1Data(rs1Data), .zero(zero), .less(less), .pc(pc), .linkPc(linkPc),
    .halted(halted));

  loadStoreUnit i_loadStoreUnit (
    .ctrl(ctrlIf.dp), .addr(aluResult), .storeData(rs2Data), .aluResult(aluResult),
    .linkPc(linkPc), .memRdata(memRdata), .memWdata(memWdata), .memMask(memMask),
    .wbData(wbData));
endmodule

`default_nettype wire

// File: sim/tbRvCore.sv
`timescale 1ns/1ns
`default_nettype none

module tbRvCore;
  localparam logic [63:0] resetPcExp = 64'h0000_0000_8000_0000;  // rvCore default

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic        instrValid;
  logic [63:0] pc;
  logic [63:0] memAddr;
  logic [63:0] memWdata;
  logic [7:0]  memMask;
  logic        memWrite;
  logic        memRead;
  logic [63:0] memRdata;
  logic        halted;
  logic        illegal;

  logic [63:0] regs [32];  // model register file
  logic [7:0]  mem [256];  // data memory, also answers memRdata
  logic [63:0] mPc;
  logic        mHalted;
  logic [31:0] seed;
  int          checks;
  int          errors;
  int          testErrors;  // error count when current test began

  rvCore i_dut (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid), .pc(pc),
    .memAddr(memAddr), .memWdata(memWdata), .memMask(memMask), .memWrite(memWrite),
    .memRead(memRead), .memRdata(memRdata), .halted(halted), .illegal(illegal));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rnd(input int n);
    return int'((lcg() >> 8) % n);  // upper bits, low ones cycle fast
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
  endfunction

  function automatic logic [63:0] laneBits(input logic [7:0] mask);
    for (int i = 0; i < 8; i++)
      laneBits[8*i +: 8] = {8{mask[i]}};  // strobe per byte
  endfunction

  function automatic logic [31:0] randArith(input logic [4:0] rd);
    logic [2:0]  f3;
    logic [4:0]  rs1;
    logic [11:0] imm;
    f3  = 3'(rnd(8));
    rs1 = 5'(rnd(32));
    imm = 12'(rnd(4096));
    if (f3 == 3'd1)
      imm[11:6] = 6'd0;  // slli takes a 6-bit shamt
    else if (f3 == 3'd5)
      imm[11:6] = {1'b0, imm[10], 4'd0};  // srli or srai
    case (rnd(4))
      0: return encR((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, imm[10], 5'd0} : 7'd0,
                     5'(rnd(32)), rs1, f3, rd, rvIsaPkg::opOp);
      1: return encI(imm, rs1, f3, rd, rvIsaPkg::opImm);
      2: return encU(20'(lcg() >> 12), rd, rvIsaPkg::opLui);
      default: return encU(20'(lcg() >> 12), rd, rvIsaPkg::opAuipc);
    endcase
  endfunction

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one clock cycle: drive, answer memory, check, then advance the model
  task automatic step(input logic [31:0] ins, input logic valid);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] iImm;
    logic [63:0] sImm;
    logic [63:0] bImm;
    logic [63:0] uImm;
    logic [63:0] jImm;
    logic [63:0] res;
    logic [63:0] nextPc;
    logic [63:0] addr;
    logic [63:0] expWdata;
    logic [63:0] lanes;
    logic [7:0]  expMask;
    logic        commit;
    logic        wen;
    logic        bad;
    logic        halt;
    logic        take;
    logic        isLoad;
    logic        isStore;
    int          sz;
    @(negedge clk);
    instr      = ins;
    instrValid = valid;
    #5;
    for (int i = 0; i < 8; i++)
      memRdata[8*i +: 8] = mem[{memAddr[7:3], 3'(i)}];  // aligned doubleword
    #5;
    rd      = ins[11:7];
    f3      = ins[14:12];
    a       = regs[ins[19:15]];
    b       = regs[ins[24:20]];
    iImm    = {{52{ins[31]}}, ins[31:20]};
    sImm    = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    bImm    = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    uImm    = {{32{ins[31]}}, ins[31:12], 12'h000};
    jImm    = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    commit  = valid && !mHalted;
    nextPc  = mPc + 64'd4;
    addr    = a + iImm;
    sz      = 1 << f3[1:0];  // access size in bytes
    res     = '0;
    wen     = 1'b0;
    bad     = 1'b0;
    halt    = 1'b0;
    take    = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (ins[6:0])
      rvIsaPkg::opLui: begin
        wen = 1'b1;
        res = uImm;
      end
      rvIsaPkg::opAuipc: begin
        wen = 1'b1;
        res = mPc + uImm;
      end
      rvIsaPkg::opJal: begin
        wen    = 1'b1;
        res    = mPc + 64'd4;
        nextPc = mPc + jImm;
      end
      rvIsaPkg::opJalr: begin
        wen    = 1'b1;
        res    = mPc + 64'd4;
        nextPc = (a + iImm) & ~64'd1;  // rs1 read before rd write
      end
      rvIsaPkg::opBranch: begin
        case (f3)
          3'b000:  take = a == b;
          3'b001:  take = a != b;
          3'b100:  take = $signed(a) < $signed(b);
          3'b101:  take = $signed(a) >= $signed(b);
          3'b110:  take = a < b;
          default: take = a >= b;
        endcase
        if (take)
          nextPc = mPc + bImm;
      end
      rvIsaPkg::opImm, rvIsaPkg::opOp: begin
        wen = 1'b1;
        if (ins[6:0] == rvIsaPkg::opImm)
          b = iImm;
        case (f3)
          3'd0:    res = (ins[30] && ins[5]) ? a - b : a + b;  // sub only in op group
          3'd1:    res = a << b[5:0];
          3'd2:    res = {63'd0, $signed(a) < $signed(b)};
          3'd3:    res = {63'd0, a < b};
          3'd4:    res = a ^ b;
          3'd5: begin
            if (ins[30])
              res = $signed(a) >>> b[5:0];
            else
              res = a >> b[5:0];
          end
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      end
      rvIsaPkg::opLoad: begin
        wen    = 1'b1;
        isLoad = 1'b1;
        for (int i = 0; i < 8; i++)
          res[8*i +: 8] = (i < sz) ? mem[addr[7:0] + 8'(i)] : 8'h00;
        for (int i = 8 * sz; i < 64; i++)
          res[i] = f3[2] ? 1'b0 : res[8 * sz - 1];  // zero or sign fill
      end
      rvIsaPkg::opStore: begin
        isStore = 1'b1;
        addr    = a + sImm;
      end
      rvIsaPkg::opSystem: begin
        if (ins == 32'h0010_0073)
          halt = 1'b1;  // ebreak
        else
          bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    expMask  = 8'((9'd1 << sz) - 9'd1) << addr[2:0];
    expWdata = b << {addr[2:0], 3'b000};
    lanes    = laneBits(expMask);
    checkEq(pc, mPc, "pc");
    checkEq(illegal, valid & bad, "illegal");
    checkEq(halted, mHalted, "halted");
    checkEq(memWrite, commit & isStore, "memWrite");
    checkEq(memRead, commit & isLoad, "memRead");
    if (commit && (isLoad || isStore))
      checkEq(memAddr, addr, "memAddr");
    if (commit && isStore) begin
      checkEq(memMask, expMask, "memMask");
      checkEq(memWdata & lanes, expWdata & lanes, "memWdata lanes");
    end
    if (commit) begin
      if (wen && rd != 5'd0)
        regs[rd] = res;
      if (isStore) begin
        for (int i = 0; i < sz; i++)
          mem[addr[7:0] + 8'(i)] = b[8*i +: 8];
      end
      if (halt)
        mHalted = 1'b1;
      mPc = nextPc;
    end
  endtask

  task automatic idle();
    logic [31:0] r;
    r = lcg();
    step({r[31:7], rvIsaPkg::opImm}, 1'b0);  // never a store, so no alignment noise
  endtask

  task automatic issue(input logic [31:0] ins);
    if (rnd(5) == 0)
      idle();  // random instrValid gap
    step(ins, 1'b1);
  endtask

  task automatic storeReg(input logic [4:0] r);
    issue(encS(12'(rnd(32) * 8), r, 5'd0, 3'd3));  // sd r at aligned slot
  endtask

  task automatic endTest(input string name);
    $display("test %s: %0d mismatches", name, errors - testErrors);
    testErrors = errors;
  endtask

  initial begin
    logic [4:0] rd;
    logic [2:0] f3;
    int         addr;
    int         sz;
    int         waitCnt;
    reset      = 1'b1;
    instr      = 32'h0000_0013;  // addi x0, x0, 0
    instrValid = 1'b0;
    memRdata   = '0;
    seed       = 32'd50;
    checks     = 0;
    errors     = 0;
    testErrors = 0;
    mPc        = resetPcExp;
    mHalted    = 1'b0;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37 + 91);
    repeat (2) @(negedge clk);
    reset = 1'b0;

    checkEq(pc, resetPcExp, "pc after reset");
    repeat (6) idle();  // pc must hold
    endTest("1 reset and stall");

    for (int n = 0; n < 40; n++) begin
      rd = 5'(rnd(31) + 1);
      issue(randArith(rd));
      storeReg(rd);
    end
    endTest("2 arithmetic");

    for (int n = 0; n < 30; n++) begin
      rd = 5'(rnd(31) + 1);
      case (rnd(3))
        0: begin
          f3 = 3'(rnd(6));
          if (f3 > 3'd1)
            f3 = f3 + 3'd2;  // skip reserved 2 and 3
          addr = rnd(32);
          issue(encB(13'(rnd(2048) * 2), (rnd(3) == 0) ? 5'(addr) : 5'(rnd(32)),
                     5'(addr), f3));
        end
        1: begin
          issue(encJ(21'((rnd(4096) - 2048) * 2), rd));
          storeReg(rd);
        end
        default: begin
          issue(encI(12'(rnd(4096)), 5'(rnd(32)), 3'd0, rd, rvIsaPkg::opJalr));
          storeReg(rd);
        end
      endcase
    end
    endTest("3 control flow");

    for (int n = 0; n < 30; n++) begin
      rd   = 5'(rnd(31) + 1);
      sz   = rnd(4);  // log2 of store width
      addr = rnd(256 >> sz) << sz;
      issue(encS(12'(addr), 5'(rnd(32)), 5'd0, 3'(sz)));
      f3   = 3'(rnd(7));
      addr = (addr >> f3[1:0]) << f3[1:0];  // same spot, aligned for load
      issue(encI(12'(addr), 5'd0, f3, rd, rvIsaPkg::opLoad));
      storeReg(rd);
    end
    issue(encI(12'd16, 5'd0, 3'd3, 5'd0, rvIsaPkg::opLoad));  // ld into x0
    storeReg(5'd0);
    endTest("4 loads and stores");

    issue({25'(lcg() >> 7), 7'b0001011});  // custom-0, not decoded
    storeReg(5'd3);
    step(32'h0010_0073, 1'b1);
    waitCnt = 0;
    while (!halted && waitCnt < 20) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!halted) begin
      $display("timeout: halted never went high after ebreak");
      $display("Test FAILED");
      $finish;
    end
    for (int n = 0; n < 4; n++)
      storeReg(5'(rnd(32)));  // no store may leave a halted core
    endTest("5 exceptional encodings");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end
endmodule

`default_nettype wire

// File: verilog.f
src/rvIsaPkg.sv
src/coreCtrlPkg.sv
src/ctrlBus.sv
src/instrDecoder.sv
src/immGen.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/loadStoreUnit.sv
src/rvCore.sv
sim/tbRvCore.sv
